/* fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    // basic data widths of the fetch path
    typedef logic [63:0]  addr_t;
    typedef logic [31:0]  instr_t;
    typedef logic [63:0]  word_t;
    typedef logic [127:0] line_t;

    // first pc after reset
    localparam addr_t RESET_PC = 64'h0000_0000_8000_0000;

    // 16-byte lines, so 4 byte-offset bits
    localparam int LINE_OFFSET_BITS = 4;

    // cache controller states
    typedef enum logic [1:0] {
        idle      = 2'd0,
        lookup    = 2'd1,
        refill    = 2'd2,
        fill_done = 2'd3
    } cache_state_e;

    // memory content rule shared by the memory model and the checker
    // instruction at byte address a is low word of a xor a fixed pattern
    function automatic instr_t instr_word(input addr_t a);
        return a[31:0] ^ 32'h1357_9bdf;
    endfunction

endpackage

`default_nettype wire

/* fetch_unit.sv */
`default_nettype none

module fetch_unit (
    input  logic              clk,
    input  logic              rst,
    input  fetch_pkg::addr_t  dnpc,
    input  logic              dnpc_valid,
    input  logic              block,
    input  logic              id_en,
    input  logic              cpu_ready,
    input  logic              cache_idle,
    input  fetch_pkg::word_t  cpu_rdata,
    output fetch_pkg::addr_t  pc,
    output logic              cpu_req,
    output fetch_pkg::instr_t instr,
    output logic              instr_valid,
    output logic              if_busy
);
    import fetch_pkg::*;

    // fetch wanted but not yet handed to the cache
    logic pending;
    // request accepted by the cache, reply outstanding
    logic in_flight;
    // outstanding reply belongs to an older pc
    logic stale;
    logic load;
    logic good_resp;

    // new pc only when decode does not hold the front end
    assign load = dnpc_valid && !block;

    // cache takes a request only while idle
    assign cpu_req = pending && cache_idle;

    // a reply is kept if it is current and no new pc arrives on the same edge
    assign good_resp = cpu_ready && !stale && !load;

    // busy from the start of a fetch until its instruction is valid
    assign if_busy = pending || in_flight;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (load) begin
            pc <= dnpc;
        end
    end

    // reset starts the first fetch by itself
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b1;
        end else if (load) begin
            pending <= 1'b1;
        end else if (cpu_req) begin
            pending <= 1'b0;
        end
    end

    // cpu_req and cpu_ready never coincide since the cache is busy while answering
    always_ff @(posedge clk) begin
        if (rst) begin
            in_flight <= 1'b0;
        end else if (cpu_req) begin
            in_flight <= 1'b1;
        end else if (cpu_ready) begin
            in_flight <= 1'b0;
        end
    end

    // pc replaced under a live request makes whatever comes back for it stale
    always_ff @(posedge clk) begin
        if (rst) begin
            stale <= 1'b0;
        end else if (load && (cpu_req || (in_flight && !cpu_ready))) begin
            stale <= 1'b1;
        end else if (cpu_ready) begin
            stale <= 1'b0;
        end
    end

    // pc bit 2 picks the upper or lower instruction of the word
    always_ff @(posedge clk) begin
        if (good_resp) begin
            instr <= pc[2] ? cpu_rdata[63:32] : cpu_rdata[31:0];
        end
    end

    // held until decode accepts it or the pc moves on
    always_ff @(posedge clk) begin
        if (rst) begin
            instr_valid <= 1'b0;
        end else if (good_resp) begin
            instr_valid <= 1'b1;
        end else if (id_en || load) begin
            instr_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* icache_way.sv */
`default_nettype none

module icache_way #(
    parameter int  NUM_SETS = 8,
    localparam int IDX_W    = $clog2(NUM_SETS),
    localparam int TAG_W    = 64 - fetch_pkg::LINE_OFFSET_BITS - IDX_W
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [IDX_W-1:0] lookup_index,
    input  logic [TAG_W-1:0] lookup_tag,
    input  logic             fill_we,
    input  fetch_pkg::line_t fill_line,
    output logic             hit,
    output fetch_pkg::line_t line
);
    import fetch_pkg::*;

    // per-set state of this way
    logic [NUM_SETS-1:0] valid;
    logic [TAG_W-1:0]    tag_mem  [NUM_SETS];
    line_t               data_mem [NUM_SETS];

    // a fill marks its set valid in this way
    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (fill_we) begin
            valid[lookup_index] <= 1'b1;
        end
    end

    // fill uses the same index and tag as the missing lookup
    always_ff @(posedge clk) begin
        if (fill_we) begin
            tag_mem[lookup_index]  <= lookup_tag;
            data_mem[lookup_index] <= fill_line;
        end
    end

    // combinational read and tag compare
    assign hit  = valid[lookup_index] && (tag_mem[lookup_index] == lookup_tag);
    assign line = data_mem[lookup_index];

endmodule

`default_nettype wire

/* icache_hit_select.sv */
`default_nettype none

module icache_hit_select #(
    parameter int NUM_WAYS = 2
) (
    input  logic [NUM_WAYS-1:0] hits,
    input  fetch_pkg::line_t    lines [NUM_WAYS],
    input  logic                word_sel,
    output logic                any_hit,
    output fetch_pkg::word_t    word
);
    import fetch_pkg::*;

    line_t sel_line;

    assign any_hit = |hits;

    // walk down so the lowest hitting way wins
    // at most one way hits since a line is only ever filled into one way
    always_comb begin
        sel_line = '0;
        for (int i = NUM_WAYS - 1; i >= 0; i--) begin
            if (hits[i]) begin
                sel_line = lines[i];
            end
        end
    end

    // address bit 3 picks the 64-bit half of the line
    assign word = word_sel ? sel_line[127:64] : sel_line[63:0];

endmodule

`default_nettype wire

/* icache_ctrl.sv */
`default_nettype none

module icache_ctrl #(
    parameter int  NUM_WAYS = 2,
    parameter int  NUM_SETS = 8,
    localparam int IDX_W    = $clog2(NUM_SETS),
    localparam int TAG_W    = 64 - fetch_pkg::LINE_OFFSET_BITS - IDX_W
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                cpu_req,
    input  fetch_pkg::addr_t    cpu_addr,
    input  logic                any_hit,
    input  logic                mem_ready,
    input  fetch_pkg::line_t    mem_rdata,
    output logic                cache_idle,
    output logic                cpu_ready,
    output logic [IDX_W-1:0]    lookup_index,
    output logic [TAG_W-1:0]    lookup_tag,
    output fetch_pkg::line_t    fill_line,
    output logic [NUM_WAYS-1:0] fill_we,
    output logic                mem_req,
    output fetch_pkg::addr_t    mem_addr
);
    import fetch_pkg::*;

    // at least one bit even for a direct-mapped cache
    localparam int WAY_W = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

    cache_state_e state;
    cache_state_e state_next;

    // line address of the request being served
    logic [63-LINE_OFFSET_BITS:0] req_line;

    // round-robin victim pointer, one per set
    logic [WAY_W-1:0] repl_ptr [NUM_SETS];
    logic [WAY_W-1:0] cur_ptr;
    logic             do_fill;

    assign cache_idle = (state == idle);
    assign cpu_ready  = (state == lookup) && any_hit;

    // index and tag come from the registered address
    assign lookup_index = req_line[IDX_W-1:0];
    assign lookup_tag   = req_line[63-LINE_OFFSET_BITS -: TAG_W];

    // memory request stays up with a steady line address until mem_ready
    assign mem_req  = (state == refill);
    assign mem_addr = {req_line, {LINE_OFFSET_BITS{1'b0}}};

    // line goes straight from memory into the victim way
    assign fill_line = mem_rdata;
    assign do_fill   = (state == refill) && mem_ready;
    assign cur_ptr   = repl_ptr[lookup_index];

    always_comb begin
        for (int i = 0; i < NUM_WAYS; i++) begin
            fill_we[i] = do_fill && (cur_ptr == WAY_W'(i));
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (cpu_req) begin
                    state_next = lookup;
                end
            end
            // hit answers in this cycle, miss goes to memory
            lookup: begin
                state_next = any_hit ? idle : refill;
            end
            refill: begin
                if (mem_ready) begin
                    state_next = fill_done;
                end
            end
            // written line is looked up again
            fill_done: begin
                state_next = lookup;
            end
            default: begin
                state_next = idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_req && cache_idle) begin
            req_line <= cpu_addr[63:LINE_OFFSET_BITS];
        end
    end

    // pointer moves past the way that was just filled
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                repl_ptr[s] <= '0;
            end
        end else if (do_fill) begin
            if (cur_ptr == WAY_W'(NUM_WAYS - 1)) begin
                repl_ptr[lookup_index] <= '0;
            end else begin
                repl_ptr[lookup_index] <= cur_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* icache.sv */
`default_nettype none

module icache #(
    parameter int  NUM_WAYS = 2,
    parameter int  NUM_SETS = 8,
    localparam int IDX_W    = $clog2(NUM_SETS),
    localparam int TAG_W    = 64 - fetch_pkg::LINE_OFFSET_BITS - IDX_W
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             cpu_req,
    input  fetch_pkg::addr_t cpu_addr,
    output logic             cpu_ready,
    output fetch_pkg::word_t cpu_rdata,
    output logic             cache_idle,
    output logic             mem_req,
    output fetch_pkg::addr_t mem_addr,
    input  logic             mem_ready,
    input  fetch_pkg::line_t mem_rdata
);
    import fetch_pkg::*;

    // broadcast to every way
    logic [IDX_W-1:0] lookup_index;
    logic [TAG_W-1:0] lookup_tag;
    line_t            fill_line;

    // one bit or line per way
    logic [NUM_WAYS-1:0] fill_we;
    logic [NUM_WAYS-1:0] way_hits;
    line_t               way_lines [NUM_WAYS];

    logic any_hit;
    // word half of the registered request
    logic word_sel_q;

    always_ff @(posedge clk) begin
        if (cpu_req && cache_idle) begin
            word_sel_q <= cpu_addr[LINE_OFFSET_BITS-1];
        end
    end

    icache_ctrl #(
        .NUM_WAYS (NUM_WAYS),
        .NUM_SETS (NUM_SETS)
    ) i_icache_ctrl (
        .clk          (clk),
        .rst          (rst),
        .cpu_req      (cpu_req),
        .cpu_addr     (cpu_addr),
        .any_hit      (any_hit),
        .mem_ready    (mem_ready),
        .mem_rdata    (mem_rdata),
        .cache_idle   (cache_idle),
        .cpu_ready    (cpu_ready),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .fill_line    (fill_line),
        .fill_we      (fill_we),
        .mem_req      (mem_req),
        .mem_addr     (mem_addr)
    );

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        icache_way #(
            .NUM_SETS (NUM_SETS)
        ) i_icache_way (
            .clk          (clk),
            .rst          (rst),
            .lookup_index (lookup_index),
            .lookup_tag   (lookup_tag),
            .fill_we      (fill_we[w]),
            .fill_line    (fill_line),
            .hit          (way_hits[w]),
            .line         (way_lines[w])
        );
    end

    icache_hit_select #(
        .NUM_WAYS (NUM_WAYS)
    ) i_icache_hit_select (
        .hits     (way_hits),
        .lines    (way_lines),
        .word_sel (word_sel_q),
        .any_hit  (any_hit),
        .word     (cpu_rdata)
    );

endmodule

`default_nettype wire

/* fetch_top.sv */
`default_nettype none

module fetch_top #(
    parameter int NUM_WAYS = 2,
    parameter int NUM_SETS = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  fetch_pkg::addr_t  dnpc,
    input  logic              dnpc_valid,
    input  logic              block,
    input  logic              id_en,
    input  logic              mem_ready,
    input  fetch_pkg::line_t  mem_rdata,
    output fetch_pkg::addr_t  pc,
    output fetch_pkg::instr_t instr,
    output logic              instr_valid,
    output logic              if_busy,
    output logic              mem_req,
    output fetch_pkg::addr_t  mem_addr
);
    import fetch_pkg::*;

    // fetch unit to cache
    logic  cpu_req;
    logic  cpu_ready;
    logic  cache_idle;
    word_t cpu_rdata;

    fetch_unit i_fetch_unit (
        .clk         (clk),
        .rst         (rst),
        .dnpc        (dnpc),
        .dnpc_valid  (dnpc_valid),
        .block       (block),
        .id_en       (id_en),
        .cpu_ready   (cpu_ready),
        .cache_idle  (cache_idle),
        .cpu_rdata   (cpu_rdata),
        .pc          (pc),
        .cpu_req     (cpu_req),
        .instr       (instr),
        .instr_valid (instr_valid),
        .if_busy     (if_busy)
    );

    // request address is the current pc
    icache #(
        .NUM_WAYS (NUM_WAYS),
        .NUM_SETS (NUM_SETS)
    ) i_icache (
        .clk        (clk),
        .rst        (rst),
        .cpu_req    (cpu_req),
        .cpu_addr   (pc),
        .cpu_ready  (cpu_ready),
        .cpu_rdata  (cpu_rdata),
        .cache_idle (cache_idle),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .mem_ready  (mem_ready),
        .mem_rdata  (mem_rdata)
    );

endmodule

`default_nettype wire

/* tb_mem_model.sv */
`default_nettype none

module tb_mem_model (
    input  logic             clk,
    input  logic             mem_req,
    input  fetch_pkg::addr_t mem_addr,
    output logic             mem_ready,
    output fetch_pkg::line_t mem_rdata,
    output int               refill_count,
    output int               proto_errors
);
    timeunit 1ns;
    timeprecision 1ps;
    import fetch_pkg::*;

    // request being served and cycles left until mem_ready
    logic        busy;
    int          wait_left;
    addr_t       req_addr;
    logic [31:0] lcg_state;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // four instructions of a line, lowest address in the low bits
    function automatic line_t line_at(input addr_t a);
        return {instr_word(a + 64'd12), instr_word(a + 64'd8),
                instr_word(a + 64'd4), instr_word(a)};
    endfunction

    initial begin
        mem_ready    = 1'b0;
        mem_rdata    = '0;
        refill_count = 0;
        proto_errors = 0;
        busy         = 1'b0;
        wait_left    = 0;
        req_addr     = '0;
        lcg_state    = 32'he79;
    end

    // runs on the falling edge so the cache sees steady inputs
    always @(negedge clk) begin
        if (busy) begin
            if (!mem_req || mem_addr != req_addr) begin
                $display("memory request dropped or moved before mem_ready at %0t", $time);
                proto_errors = proto_errors + 1;
            end
            wait_left = wait_left - 1;
            if (wait_left == 0) begin
                mem_ready = 1'b1;
                mem_rdata = line_at(req_addr);
                busy      = 1'b0;
            end
        end else if (mem_ready) begin
            // mem_ready lasts one cycle
            mem_ready = 1'b0;
        end else if (mem_req) begin
            if (mem_addr[LINE_OFFSET_BITS-1:0] != '0) begin
                $display("memory request at %0t is not line aligned: %h", $time, mem_addr);
                proto_errors = proto_errors + 1;
            end
            // latency of 1 to 8 cycles
            lcg_state    = lcg_next(lcg_state);
            wait_left    = 1 + int'(lcg_state[18:16]);
            req_addr     = mem_addr;
            busy         = 1'b1;
            refill_count = refill_count + 1;
        end
    end

endmodule

`default_nettype wire

/* tb_fetch_top.sv */
`default_nettype none

module tb_fetch_top;
    timeunit 1ns;
    timeprecision 1ps;
    import fetch_pkg::*;

    // cycles allowed for one fetch, and cycles watched after a held strobe
    localparam int WAIT_LIMIT  = 200;
    localparam int IDLE_WINDOW = 6;

    logic   clk = 1'b0;
    logic   rst;
    addr_t  dnpc;
    logic   dnpc_valid;
    logic   block;
    logic   id_en;
    logic   mem_ready;
    line_t  mem_rdata;
    addr_t  pc;
    instr_t instr;
    logic   instr_valid;
    logic   if_busy;
    logic   mem_req;
    addr_t  mem_addr;

    int   refill_count;
    int   proto_errors;
    int   value_errors = 0;
    int   other_errors = 0;
    logic timed_out    = 1'b0;

    always #10 clk = ~clk;

    fetch_top #(
        .NUM_WAYS (2),
        .NUM_SETS (8)
    ) i_fetch_top (
        .clk         (clk),
        .rst         (rst),
        .dnpc        (dnpc),
        .dnpc_valid  (dnpc_valid),
        .block       (block),
        .id_en       (id_en),
        .mem_ready   (mem_ready),
        .mem_rdata   (mem_rdata),
        .pc          (pc),
        .instr       (instr),
        .instr_valid (instr_valid),
        .if_busy     (if_busy),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr)
    );

    tb_mem_model i_mem (
        .clk          (clk),
        .mem_req      (mem_req),
        .mem_addr     (mem_addr),
        .mem_ready    (mem_ready),
        .mem_rdata    (mem_rdata),
        .refill_count (refill_count),
        .proto_errors (proto_errors)
    );

    task automatic check_instr(input string name, input instr_t exp, input instr_t act);
        if (act !== exp) begin
            $display("error at %0t: %s expected %h, got %h", $time, name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            $display("error at %0t: %s expected %h, got %h", $time, name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error at %0t: %s expected %b, got %b", $time, name, exp, act);
            value_errors++;
        end
    endtask

    // sampled on the falling edge between the DUT's clock edges
    task automatic wait_instr_valid(input int limit);
        int cycles;
        cycles = 0;
        while (instr_valid !== 1'b1 && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (instr_valid !== 1'b1) begin
            $display("timeout at %0t: instr_valid did not rise within %0d cycles", $time, limit);
            other_errors++;
            timed_out = 1'b1;
        end
    endtask

    // a held strobe must leave the front end quiet
    task automatic watch_no_fetch(input int window);
        int   cycles;
        logic moved;
        cycles = 0;
        moved  = 1'b0;
        while (cycles < window) begin
            if (instr_valid !== 1'b0 || if_busy !== 1'b0 || mem_req !== 1'b0) begin
                moved = 1'b1;
            end
            @(negedge clk);
            cycles++;
        end
        if (moved) begin
            $display("a fetch started at %0t although block was high", $time);
            other_errors++;
        end
    endtask

    // one golden row gives strobe, wait for the instruction, check and accept
    task automatic run_step(input int idx, input addr_t next_pc, input logic hold,
                            input instr_t exp_instr, input int exp_refills);
        int    refills_before;
        addr_t pc_before;
        refills_before = refill_count;
        pc_before      = pc;
        // the reset fetch needs no strobe
        if (idx > 0) begin
            dnpc       = next_pc;
            block      = hold;
            dnpc_valid = 1'b1;
            @(negedge clk);
            dnpc_valid = 1'b0;
            block      = 1'b0;
        end
        if (hold) begin
            watch_no_fetch(IDLE_WINDOW);
            check_addr("pc", pc_before, pc);
        end else begin
            // fetch is pending from the strobe edge on
            check_flag("if_busy", 1'b1, if_busy);
            wait_instr_valid(WAIT_LIMIT);
            if (!timed_out) begin
                check_instr("instr", exp_instr, instr);
                check_addr("pc", next_pc, pc);
                check_flag("if_busy", 1'b0, if_busy);
                id_en = 1'b1;
                @(negedge clk);
                id_en = 1'b0;
                check_flag("instr_valid", 1'b0, instr_valid);
            end
        end
        if (!timed_out) begin
            check_count("refill count", exp_refills, refill_count - refills_before);
        end
    endtask

    initial begin
        int     fd;
        int     n;
        int     steps;
        int     g_block;
        int     g_refill;
        addr_t  g_pc;
        instr_t g_instr;
        string  line;

        rst        = 1'b1;
        dnpc       = '0;
        dnpc_valid = 1'b0;
        block      = 1'b0;
        id_en      = 1'b0;
        steps      = 0;

        fd = $fopen("fetch_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open fetch_golden.txt");
            other_errors++;
        end

        repeat (5) @(negedge clk);
        // reset fetch is pending, nothing else has moved
        check_flag("mem_req", 1'b0, mem_req);
        check_flag("instr_valid", 1'b0, instr_valid);
        check_flag("if_busy", 1'b1, if_busy);
        rst = 1'b0;

        while (fd != 0 && !timed_out && $fgets(line, fd) != 0) begin
            // skip the column header and blank lines
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %d %h %d", g_pc, g_block, g_instr, g_refill);
            if (n != 4) begin
                $display("golden line could not be read: %s", line);
                other_errors++;
                continue;
            end
            // the expected instruction follows the memory content rule
            if (g_block == 0 && g_instr !== instr_word(g_pc)) begin
                $display("golden row for pc %h breaks the memory content rule", g_pc);
                other_errors++;
            end
            run_step(steps, g_pc, g_block != 0, g_instr, g_refill);
            steps++;
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (steps == 0) begin
            $display("no steps were read from fetch_golden.txt");
            other_errors++;
        end

        $display("%0d steps, %0d value errors, %0d other errors, %0d memory protocol errors",
                 steps, value_errors, other_errors, proto_errors);
        if (value_errors == 0 && other_errors == 0 && proto_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* fetch_golden.txt */
# columns: next pc (hex), block flag, expected instruction (hex), refills expected
# first row is the fetch that reset starts by itself, it gets no dnpc strobe
80000000 0 93579bdf 1
80000004 0 93579bdb 0
80000008 0 93579bd7 0
8000000c 0 93579bd3 0
80000010 0 93579bcf 1
8000002c 0 93579bf3 1
80000134 0 93579aeb 1
80000130 0 93579aef 0
80000200 1 00000000 0
80000200 0 935799df 1
80001050 0 93578b8f 1
80002050 0 9357bb8f 1
80003050 0 9357ab8f 1
80002054 0 9357bb8b 0
80001058 0 93578b87 1
80000204 0 935799db 0

/* sim.f */
fetch_pkg.sv
fetch_unit.sv
icache_way.sv
icache_hit_select.sv
icache_ctrl.sv
icache.sv
fetch_top.sv
tb_mem_model.sv
tb_fetch_top.sv

/* Makefile */
# Verilator build and run of the fetch front end testbench

SIM := obj_dir/Vtb_fetch_top

.PHONY: all run clean

all: run

# rebuilt only when the file list or a source changes
$(SIM): sim.f $(shell cat sim.f)
	verilator --binary --timing -j 0 --top-module tb_fetch_top -f sim.f

run: $(SIM) fetch_golden.txt
	./$(SIM) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Errors found" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "No errors" sim.log || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf obj_dir sim.log
